// File: rtl/lock_pkg.sv
`default_nettype none

package lock_pkg;

    typedef logic [3:0]  digit_t;    // bcd digit, F shows blank
    typedef logic [11:0] display_t;  // nibble 0 is the newest digit
    typedef logic [2:0]  tries_t;
    typedef logic [31:0] cycle_t;    // tone timing in clock cycles

    typedef enum logic [1:0] {
        key_digit,
        key_enter,
        key_clear,
        key_master_clear
    } key_kind_e;

    typedef struct packed {
        logic      valid;
        key_kind_e kind;
        digit_t    digit;  // only meaningful for key_digit
    } key_event_t;

    typedef enum logic [1:0] {
        tone_digit,
        tone_success,
        tone_fail
    } tone_e;

    typedef struct packed {
        logic  start;  // one-cycle strobe, restarts a running burst
        tone_e kind;
    } tone_req_t;

    typedef enum logic [1:0] {
        st_entry,
        st_open,
        st_lockout
    } lock_state_e;

    localparam display_t disp_blank   = 12'hFFF;
    localparam display_t disp_open    = 12'hBCC;
    localparam display_t disp_lockout = 12'h000;

endpackage

`default_nettype wire

// File: rtl/key_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module key_decoder (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic [15:0]         onehot,
    output lock_pkg::key_event_t     key
);
    import lock_pkg::*;

    logic [15:0] onehot_q;  // current sample
    logic [15:0] prev_q;    // sample before it
    key_event_t  key_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            onehot_q <= '0;
            prev_q   <= '0;
        end else begin
            onehot_q <= onehot;
            prev_q   <= onehot_q;
        end
    end

    // map the sampled lines to an event, unmapped or multi-hot gives none
    always_comb begin
        key_next.valid = 1'b1;
        key_next.kind  = key_digit;
        key_next.digit = 4'hF;
        case (onehot_q)
            16'h0008: key_next.digit = 4'd0;
            16'h0080: key_next.digit = 4'd1;
            16'h0040: key_next.digit = 4'd2;
            16'h0020: key_next.digit = 4'd3;
            16'h0800: key_next.digit = 4'd4;
            16'h0400: key_next.digit = 4'd5;
            16'h0200: key_next.digit = 4'd6;
            16'h8000: key_next.digit = 4'd7;
            16'h4000: key_next.digit = 4'd8;
            16'h2000: key_next.digit = 4'd9;
            16'h0001: key_next.kind  = key_enter;
            16'h1000: key_next.kind  = key_clear;
            16'h0100: key_next.kind  = key_master_clear;
            default:  key_next.valid = 1'b0;
        endcase
        if (onehot_q == prev_q) begin
            key_next.valid = 1'b0;  // held key, no repeat
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            key <= '0;
        end else begin
            key <= key_next;
        end
    end

endmodule

`default_nettype wire

// File: rtl/code_entry.sv
`timescale 1ns/1ps
`default_nettype none

module code_entry (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                shift_in,
    input  wire lock_pkg::digit_t    digit,
    input  wire logic                clear,
    input  wire logic                load_open,
    input  wire logic                load_lockout,
    output lock_pkg::display_t       entry,
    output logic                     full
);
    import lock_pkg::*;

    logic [1:0] count;  // digits held, saturates at 3

    always_ff @(posedge clk) begin
        if (rst) begin
            entry <= disp_blank;
            count <= 2'd0;
        end else if (load_lockout) begin
            entry <= disp_lockout;
            count <= 2'd0;
        end else if (load_open) begin
            entry <= disp_open;
            count <= 2'd0;
        end else if (clear) begin
            entry <= disp_blank;
            count <= 2'd0;
        end else if (shift_in && count != 2'd3) begin
            entry <= {entry[7:0], digit};  // newest digit lands in nibble 0
            count <= count + 2'd1;
        end
    end

    assign full = (count == 2'd3);

endmodule

`default_nettype wire

// File: rtl/lock_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module lock_fsm #(
    parameter lock_pkg::display_t lock_code = 12'h246,
    parameter lock_pkg::tries_t   max_tries = 3'd6
) (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire lock_pkg::key_event_t    key,
    input  wire lock_pkg::display_t      entry,
    input  wire logic                    full,
    output logic                         shift_in,
    output lock_pkg::digit_t             digit,
    output logic                         clear,
    output logic                         load_open,
    output logic                         load_lockout,
    output lock_pkg::tone_req_t          tone,
    output lock_pkg::tries_t             tries,
    output logic                         unlocked
);
    import lock_pkg::*;

    lock_state_e state;
    lock_state_e state_next;
    tries_t      tries_next;
    tries_t      tries_inc;
    tone_req_t   tone_next;

    assign tries_inc = tries + 3'd1;
    assign digit     = key.digit;

    always_comb begin
        state_next     = state;
        tries_next     = tries;
        tone_next      = '0;
        shift_in       = 1'b0;
        clear          = 1'b0;
        load_open      = 1'b0;
        load_lockout   = 1'b0;
        if (key.valid) begin
            if (key.kind == key_master_clear) begin
                // acts from every state, including lockout
                tries_next = '0;
                clear      = 1'b1;
                state_next = st_entry;
            end else begin
                case (state)
                    st_entry: begin
                        case (key.kind)
                            key_digit: begin
                                shift_in       = 1'b1;
                                tone_next.start = 1'b1;
                                tone_next.kind  = tone_digit;
                            end
                            key_enter: begin
                                if (full && entry == lock_code) begin
                                    load_open       = 1'b1;
                                    state_next      = st_open;
                                    tone_next.start = 1'b1;
                                    tone_next.kind  = tone_success;
                                end else if (full) begin
                                    tries_next      = tries_inc;
                                    tone_next.start = 1'b1;
                                    tone_next.kind  = tone_fail;
                                    if (tries_inc >= max_tries) begin
                                        load_lockout = 1'b1;  // show 000
                                        state_next   = st_lockout;
                                    end else begin
                                        clear = 1'b1;
                                    end
                                end
                            end
                            key_clear: clear = 1'b1;
                            default: ;
                        endcase
                    end
                    st_open: begin
                        if (key.kind == key_clear) begin
                            clear      = 1'b1;
                            state_next = st_entry;
                        end
                    end
                    default: ;  // lockout waits for master clear
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_entry;
            tries <= '0;
            tone  <= '0;
        end else begin
            state <= state_next;
            tries <= tries_next;
            tone  <= tone_next;
        end
    end

    assign unlocked = (state == st_open);

endmodule

`default_nettype wire

// File: rtl/tone_timer.sv
`timescale 1ns/1ps
`default_nettype none

module tone_timer #(
    parameter lock_pkg::cycle_t digit_half   = 32'd50000,
    parameter lock_pkg::cycle_t success_half = 32'd25000,
    parameter lock_pkg::cycle_t fail_half    = 32'd100000,
    parameter lock_pkg::cycle_t digit_len    = 32'd10000000,
    parameter lock_pkg::cycle_t success_len  = 32'd30000000,
    parameter lock_pkg::cycle_t fail_len     = 32'd30000000
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire lock_pkg::tone_req_t   tone,
    output logic                       buzzer
);
    import lock_pkg::*;

    // silent window of the fail tone
    localparam cycle_t fail_lo = fail_len / 3;
    localparam cycle_t fail_hi = fail_len - fail_lo;

    logic   active;
    logic   wave;       // square wave before muting
    tone_e  kind_q;
    cycle_t burst_cnt;  // cycles since start
    cycle_t half_cnt;   // cycles since last toggle
    cycle_t half_sel;
    cycle_t len_sel;
    logic   mute;

    always_comb begin
        case (kind_q)
            tone_success: begin
                half_sel = success_half;
                len_sel  = success_len;
            end
            tone_fail: begin
                half_sel = fail_half;
                len_sel  = fail_len;
            end
            default: begin
                half_sel = digit_half;
                len_sel  = digit_len;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active    <= 1'b0;
            wave      <= 1'b0;
            kind_q    <= tone_digit;
            burst_cnt <= '0;
            half_cnt  <= '0;
        end else if (tone.start) begin
            active    <= 1'b1;  // restart even if a burst is running
            wave      <= 1'b1;
            kind_q    <= tone.kind;
            burst_cnt <= '0;
            half_cnt  <= '0;
        end else if (active) begin
            burst_cnt <= burst_cnt + cycle_t'(1);
            if (half_cnt + cycle_t'(1) >= half_sel) begin
                wave     <= ~wave;
                half_cnt <= '0;
            end else begin
                half_cnt <= half_cnt + cycle_t'(1);
            end
            if (burst_cnt + cycle_t'(1) >= len_sel) begin
                active <= 1'b0;  // end of burst, force low
                wave   <= 1'b0;
            end
        end
    end

    assign mute   = (kind_q == tone_fail) && (burst_cnt >= fail_lo) && (burst_cnt < fail_hi);
    assign buzzer = wave & ~mute;

endmodule

`default_nettype wire

// File: rtl/keypad_lock_top.sv
`timescale 1ns/1ps
`default_nettype none

module keypad_lock_top #(
    parameter lock_pkg::display_t lock_code    = 12'h246,
    parameter lock_pkg::tries_t   max_tries    = 3'd6,
    parameter lock_pkg::cycle_t   digit_half   = 32'd50000,
    parameter lock_pkg::cycle_t   success_half = 32'd25000,
    parameter lock_pkg::cycle_t   fail_half    = 32'd100000,
    parameter lock_pkg::cycle_t   digit_len    = 32'd10000000,
    parameter lock_pkg::cycle_t   success_len  = 32'd30000000,
    parameter lock_pkg::cycle_t   fail_len     = 32'd30000000
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic [15:0]         onehot,
    output lock_pkg::display_t       display,
    output lock_pkg::tries_t         tries,
    output logic                     unlocked,
    output logic                     buzzer
);
    import lock_pkg::*;

    key_event_t key;
    tone_req_t  tone;
    digit_t     digit;
    logic       shift_in;
    logic       clear;
    logic       load_open;
    logic       load_lockout;
    logic       full;

    key_decoder u_key_decoder (
        .clk    (clk),
        .rst    (rst),
        .onehot (onehot),
        .key    (key)
    );

    code_entry u_code_entry (
        .clk          (clk),
        .rst          (rst),
        .shift_in     (shift_in),
        .digit        (digit),
        .clear        (clear),
        .load_open    (load_open),
        .load_lockout (load_lockout),
        .entry        (display),  // entry register drives the display directly
        .full         (full)
    );

    lock_fsm #(
        .lock_code (lock_code),
        .max_tries (max_tries)
    ) u_lock_fsm (
        .clk          (clk),
        .rst          (rst),
        .key          (key),
        .entry        (display),
        .full         (full),
        .shift_in     (shift_in),
        .digit        (digit),
        .clear        (clear),
        .load_open    (load_open),
        .load_lockout (load_lockout),
        .tone         (tone),
        .tries        (tries),
        .unlocked     (unlocked)
    );

    tone_timer #(
        .digit_half   (digit_half),
        .success_half (success_half),
        .fail_half    (fail_half),
        .digit_len    (digit_len),
        .success_len  (success_len),
        .fail_len     (fail_len)
    ) u_tone_timer (
        .clk    (clk),
        .rst    (rst),
        .tone   (tone),
        .buzzer (buzzer)
    );

endmodule

`default_nettype wire

// File: bench/lock_model.svh
`ifndef LOCK_MODEL_SVH
`define LOCK_MODEL_SVH

// key codes 0 to 9 are the digits
localparam int kc_enter  = 10;
localparam int kc_clear  = 11;
localparam int kc_master = 12;

// key code of each keypad line or -1 where unused
localparam int key_code_at [16] = '{10, -1, -1, 0, -1, 3, 2, 1, 12, 6, 5, 4, 11, 9, 8, 7};

lock_state_e m_state;
display_t    m_display;
tries_t      m_tries;
int          m_count;      // digits in the entry
tone_e       m_tone_kind;  // tone of the last beeping press

task automatic model_reset();
    m_state     = st_entry;
    m_display   = disp_blank;
    m_tries     = '0;
    m_count     = 0;
    m_tone_kind = tone_digit;
endtask

function automatic int key_code(input logic [15:0] pattern);
    if ($countones(pattern) != 1) return -1;  // zero or several lines
    for (int b = 0; b < 16; b++) begin
        if (pattern[b]) return key_code_at[b];
    end
    return -1;
endfunction

task automatic model_press(input logic [15:0] pattern);
    int code;
    code = key_code(pattern);
    if (code == kc_master) begin
        m_tries   = '0;
        m_display = disp_blank;
        m_count   = 0;
        m_state   = st_entry;
    end else if (m_state == st_entry && code >= 0 && code <= 9) begin
        if (m_count < 3) begin
            m_display = {m_display[7:0], 4'(code)};
            m_count++;
        end
        m_tone_kind = tone_digit;  // beeps even when the entry is full
    end else if (m_state == st_entry && code == kc_enter && m_count == 3) begin
        m_count = 0;
        if (m_display == secret_code) begin
            m_state     = st_open;
            m_display   = disp_open;
            m_tone_kind = tone_success;
        end else begin
            m_tries     = m_tries + 3'd1;
            m_tone_kind = tone_fail;
            m_display   = (m_tries >= try_limit) ? disp_lockout : disp_blank;
            if (m_tries >= try_limit) m_state = st_lockout;
        end
    end else if (m_state != st_lockout && code == kc_clear) begin
        m_state   = st_entry;
        m_display = disp_blank;
        m_count   = 0;
    end
endtask

`endif

// File: bench/tb_keypad_lock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_keypad_lock;
    import lock_pkg::*;

    localparam display_t secret_code  = 12'h246;
    localparam tries_t   try_limit    = 3'd6;
    localparam cycle_t   digit_half   = 32'd1;
    localparam cycle_t   success_half = 32'd1;
    localparam cycle_t   fail_half    = 32'd2;
    localparam cycle_t   digit_len    = 32'd4;
    localparam cycle_t   success_len  = 32'd6;
    localparam cycle_t   fail_len     = 32'd24;
    localparam int       quiet_cycles = 40;  // longer than any gap inside a burst

    localparam logic [15:0] unused_keys [4] = '{16'h0000, 16'h0002, 16'h0004, 16'h0010};

    logic        clk;
    logic        rst;
    logic [15:0] onehot;
    display_t    display;
    tries_t      tries;
    logic        unlocked;
    logic        buzzer;
    logic [31:0] lfsr;
    int          checks;
    int          errors;
    int          test_no;
    int          test_err0;
    string       test_name;

    `include "lock_model.svh"

    keypad_lock_top #(
        .lock_code    (secret_code),
        .max_tries    (try_limit),
        .digit_half   (digit_half),
        .success_half (success_half),
        .fail_half    (fail_half),
        .digit_len    (digit_len),
        .success_len  (success_len),
        .fail_len     (fail_len)
    ) u_dut (
        .clk      (clk),
        .rst      (rst),
        .onehot   (onehot),
        .display  (display),
        .tries    (tries),
        .unlocked (unlocked),
        .buzzer   (buzzer)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic lfsr_bit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) lfsr = lfsr ^ 32'h80200003;  // galois taps 32,22,2,1
        return b;
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_bit());
        end
        return v;
    endfunction

    function automatic logic [15:0] pattern_of(input int code);
        for (int b = 0; b < 16; b++) begin
            if (key_code_at[b] == code) return 16'(1) << b;
        end
        return '0;
    endfunction

    function automatic display_t wrong_code();
        display_t c;
        c = {4'(rand_bits(4) % 10), 4'(rand_bits(4) % 10), 4'(rand_bits(4) % 10)};
        if (c == secret_code) c[3:0] = 4'd7;
        return c;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $finish;
    endtask

    task automatic check_outputs();
        checks += 3;
        assert (display == m_display) else begin
            $display("Error at %0t ns: display %h, expected %h", $time, display, m_display);
            errors++;
        end
        assert (tries == m_tries) else begin
            $display("Error at %0t ns: tries %0d, expected %0d", $time, tries, m_tries);
            errors++;
        end
        assert (unlocked == (m_state == st_open)) else begin
            $display("Error at %0t ns: unlocked %b in state %s", $time, unlocked, m_state.name());
            errors++;
        end
    endtask

    // event reaches the outputs three edges after the lines change
    task automatic press_key(input logic [15:0] pattern, input int hold);
        @(posedge clk);
        onehot <= pattern;
        repeat (hold) @(posedge clk);
        onehot <= '0;
        if (hold < 3) repeat (3 - hold) @(posedge clk);
        @(negedge clk);
        model_press(pattern);
        check_outputs();
    endtask

    task automatic tap_key(input logic [15:0] pattern);
        press_key(pattern, 1);
        repeat (rand_bits(2)) @(posedge clk);  // idle gap
    endtask

    task automatic enter_digits(input display_t c);
        tap_key(pattern_of(int'(c[11:8])));
        tap_key(pattern_of(int'(c[7:4])));
        tap_key(pattern_of(int'(c[3:0])));
    endtask

    task automatic wait_quiet();
        int low;
        low = 0;
        for (int i = 0; i < 1000 && low < quiet_cycles; i++) begin
            @(negedge clk);
            low = buzzer ? 0 : low + 1;
        end
        if (low < quiet_cycles) begin
            $display("buzzer kept sounding for 1000 cycles");
            errors++;
        end
    endtask

    // called on the falling edge right after the state update
    task automatic buzz_check();
        cycle_t len;
        int     rises_exp;
        int     rises;
        logic   prev;
        rises = 0;
        prev  = buzzer;
        checks += 3;
        case (m_tone_kind)
            tone_success: begin
                len       = success_len;
                rises_exp = int'(success_len / (2 * success_half));
            end
            tone_fail: begin
                len       = fail_len;
                rises_exp = int'(2 * (fail_len / 3) / (2 * fail_half));  // middle third silent
            end
            default: begin
                len       = digit_len;
                rises_exp = int'(digit_len / (2 * digit_half));
            end
        endcase
        for (int i = 0; i < int'(len) + quiet_cycles; i++) begin
            @(negedge clk);
            if (buzzer && !prev) rises++;
            if (i == 0) begin
                assert (buzzer) else begin
                    $display("Error at %0t ns: buzzer did not rise after the state update",
                             $time);
                    errors++;
                end
            end
            if (i >= int'(len)) begin
                assert (!buzzer) else begin
                    $display("Error at %0t ns: buzzer high after the burst", $time);
                    errors++;
                end
            end
            prev = buzzer;
        end
        assert (rises == rises_exp) else begin
            $display("Error at %0t ns: %0d buzzer rises, expected %0d", $time, rises, rises_exp);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_err0 = errors;
    endtask

    task automatic finish_test();
        test_no++;
        $display("test %0d, %s: %s, %0d errors", test_no, test_name,
                 (errors == test_err0) ? "pass" : "fail", errors - test_err0);
    endtask

    initial begin : stimulus
        int          pick;
        int          b0;
        int          b1;
        display_t    c;
        rst     = 1'b1;
        onehot  = '0;
        lfsr    = 32'd82124;
        checks  = 0;
        errors  = 0;
        test_no = 0;
        model_reset();
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_outputs();
        checks++;
        assert (buzzer == 1'b0) else begin
            $display("Error at %0t ns: buzzer high after reset", $time);
            errors++;
        end

        start_test("random digit entry");
        tap_key(pattern_of(kc_master));
        for (int n = 0; n < 30; n++) begin
            pick = rand_bits(3);
            if (pick < 5) begin
                tap_key(pattern_of(rand_bits(4) % 10));
            end else if (pick == 5) begin
                press_key(pattern_of(rand_bits(4) % 10), 4 + rand_bits(2));  // held key
            end else if (pick == 6) begin
                tap_key(unused_keys[rand_bits(2)]);
            end else begin
                b0 = rand_bits(4);
                b1 = (b0 + 1 + rand_bits(4) % 15) % 16;
                tap_key((16'(1) << b0) | (16'(1) << b1));  // two lines at once
            end
            if (n % 6 == 5) tap_key(pattern_of(kc_clear));
        end
        finish_test();

        start_test("correct code");
        tap_key(pattern_of(kc_master));
        enter_digits(secret_code);
        tap_key(pattern_of(kc_enter));
        tap_key(pattern_of(rand_bits(4) % 10));
        tap_key(pattern_of(kc_enter));
        tap_key(pattern_of(kc_clear));
        finish_test();

        start_test("wrong code");
        tap_key(pattern_of(kc_master));
        for (int n = 0; n < 4; n++) begin
            c = wrong_code();
            tap_key(pattern_of(int'(c[11:8])));
            tap_key(pattern_of(kc_enter));  // one digit only
            tap_key(pattern_of(int'(c[7:4])));
            tap_key(pattern_of(kc_enter));
            tap_key(pattern_of(int'(c[3:0])));
            tap_key(pattern_of(kc_enter));
        end
        finish_test();

        start_test("lockout and master clear");
        tap_key(pattern_of(kc_master));
        repeat (6) begin
            enter_digits(wrong_code());
            tap_key(pattern_of(kc_enter));
        end
        enter_digits(secret_code);
        tap_key(pattern_of(kc_enter));
        tap_key(pattern_of(kc_clear));
        tap_key(pattern_of(kc_master));
        finish_test();

        start_test("buzzer bursts");
        wait_quiet();
        press_key(pattern_of(rand_bits(4) % 10), 1);
        buzz_check();
        tap_key(pattern_of(kc_clear));
        enter_digits(secret_code);
        wait_quiet();
        press_key(pattern_of(kc_enter), 1);
        buzz_check();
        tap_key(pattern_of(kc_clear));
        enter_digits(wrong_code());
        wait_quiet();
        press_key(pattern_of(kc_enter), 1);
        buzz_check();
        finish_test();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        for (int n = 0; n < 200000; n++) begin
            @(posedge clk);
        end
        abort_run("simulation did not finish within 200000 cycles");
    end

endmodule

`default_nettype wire

// File: files.f
rtl/lock_pkg.sv
rtl/key_decoder.sv
rtl/code_entry.sv
rtl/lock_fsm.sv
rtl/tone_timer.sv
rtl/keypad_lock_top.sv
+incdir+bench
bench/tb_keypad_lock.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f files.f --top-module tb_keypad_lock -o tb_keypad_lock

./obj_dir/tb_keypad_lock > sim.log 2>&1
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
echo "simulation finished without a reported failure"
